// ==== Makefile ====
# Verilator build and run for the ingress policer testbench

VERILATOR ?= verilator
TOP       ?= policer_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary -j $(JOBS)

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The simulator exits non-zero on a failed run
run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// ==== rtl/policer_cfg_tables.sv ====
// Per-port CIR and CBS tables with write decode and port lookup
`timescale 1ns/1ns
`default_nettype none

module policer_cfg_tables #(
    parameter int NUM_PORTS = 11
) (
    input  wire                          core_clk_ifc,
    input  wire                          timer_reset,
    input  wire                          cfg_valid,
    input  wire policer_pkg::cfg_write_t cfg,
    input  wire policer_pkg::port_id_t   lookup_port,
    output policer_pkg::cir_t            cir_all [NUM_PORTS],
    output policer_pkg::cbs_t            cbs
);

    import policer_pkg::*;

    cir_t cir_table [NUM_PORTS];
    cbs_t cbs_table [NUM_PORTS];
    logic port_in_range;

    // Writes to ports past the table end are dropped
    assign port_in_range = int'(cfg.port) < NUM_PORTS;

    always_ff @(posedge core_clk_ifc) begin
        if (timer_reset) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                cir_table[p] <= '0;
                cbs_table[p] <= '0;
            end
        end else if (cfg_valid && port_in_range) begin
            case (cfg.table_sel)
                TABLE_CIR: cir_table[cfg.port] <= cfg.data[CIR_WIDTH-1:0];
                TABLE_CBS: cbs_table[cfg.port] <= cfg.data[CBS_WIDTH-1:0];
                default:   ;
            endcase
        end
    end

    ////////////////////////////////////////
    // Read side

    // Every rate feeds the drain logic in parallel
    assign cir_all = cir_table;

    always_comb begin
        if (int'(lookup_port) < NUM_PORTS) begin
            cbs = cbs_table[lookup_port];
        end else begin
            cbs = '0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/policer_ctrl.sv ====
// Two-stage descriptor pipeline with the conformance decision and the
// bucket charge
`timescale 1ns/1ns
`default_nettype none

module policer_ctrl #(
    parameter int NUM_PORTS = 11
) (
    input  wire                                          core_clk_ifc,
    input  wire                                          timer_reset,
    input  wire                                          desc_valid,
    input  wire policer_pkg::pkt_desc_t                  desc_in,
    input  wire [NUM_PORTS-1:0]                          port_enable,
    input  wire policer_pkg::cbs_t                       cbs,
    input  wire [policer_pkg::LEVEL_WHOLE_WIDTH-1:0]     level_whole,
    output policer_pkg::port_id_t                        lookup_port,
    output logic                                         charge_valid,
    output policer_pkg::byte_len_t                       charge_bytes,
    output logic                                         result_valid,
    output policer_pkg::policed_desc_t                   result
);

    import policer_pkg::*;

    // One bit wider than the level so the sum cannot wrap
    localparam int SUM_WIDTH = LEVEL_WHOLE_WIDTH + 1;

    logic             s1_valid;
    pkt_desc_t        s1_desc;

    logic             port_enabled;
    logic [SUM_WIDTH-1:0] fill_after;
    logic             over_burst;
    logic             drop_mark;

    ////////////////////////////////////////
    // Stage 1

    always_ff @(posedge core_clk_ifc) begin
        if (timer_reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= desc_valid;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (desc_valid) begin
            s1_desc <= desc_in;
        end
    end

    ////////////////////////////////////////
    // Stage 2 decision

    assign lookup_port = s1_desc.ingress_port;

    // Ports beyond NUM_PORTS are treated as disabled
    assign port_enabled = (int'(s1_desc.ingress_port) < NUM_PORTS) &&
                          port_enable[s1_desc.ingress_port];

    assign fill_after = SUM_WIDTH'(s1_desc.byte_length) + SUM_WIDTH'(level_whole);
    assign over_burst = fill_after > SUM_WIDTH'(cbs);
    assign drop_mark  = port_enabled && over_burst;

    // Only conforming packets on enabled ports fill the bucket
    assign charge_valid = s1_valid && port_enabled && !over_burst;
    assign charge_bytes = s1_desc.byte_length;

    ////////////////////////////////////////
    // Result register

    always_ff @(posedge core_clk_ifc) begin
        if (timer_reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= s1_valid;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (s1_valid) begin
            result.desc      <= s1_desc;
            result.drop_mark <= drop_mark;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/policer_pkg.sv ====
// Shared widths, fixed-point types and descriptor structs for the
// ingress policer
`default_nettype none

package policer_pkg;

    ////////////////////////////////////////
    // Widths

    localparam int PORT_ID_WIDTH     = 4;
    localparam int PRIO_WIDTH        = 3;
    localparam int BYTE_LEN_WIDTH    = 16;
    localparam int FRAC_BITS         = 8;
    localparam int CIR_WIDTH         = 16;
    localparam int CBS_WIDTH         = 24;
    localparam int LEVEL_WHOLE_WIDTH = 24;
    localparam int BUCKET_WIDTH      = LEVEL_WHOLE_WIDTH + FRAC_BITS;
    localparam int CFG_DATA_WIDTH    = 24;

    ////////////////////////////////////////
    // Scalar types

    typedef logic [PORT_ID_WIDTH-1:0]  port_id_t;
    typedef logic [PRIO_WIDTH-1:0]     prio_t;
    typedef logic [BYTE_LEN_WIDTH-1:0] byte_len_t;
    typedef logic [CBS_WIDTH-1:0]      cbs_t;

    // Bytes drained per cycle in 8.8 fixed point
    typedef logic [CIR_WIDTH-1:0] cir_t;

    // 24.8 fixed point fill level
    typedef logic [BUCKET_WIDTH-1:0] bucket_level_t;

    typedef enum logic {
        TABLE_CIR = 1'b0,
        TABLE_CBS = 1'b1
    } table_sel_e;

    ////////////////////////////////////////
    // Structs

    // CIR writes only use the low CIR_WIDTH bits of data
    typedef struct packed {
        table_sel_e                table_sel;
        port_id_t                  port;
        logic [CFG_DATA_WIDTH-1:0] data;
    } cfg_write_t;

    typedef struct packed {
        port_id_t  ingress_port;
        port_id_t  egress_port;
        prio_t     prio;
        byte_len_t byte_length;
    } pkt_desc_t;

    typedef struct packed {
        pkt_desc_t desc;
        logic      drop_mark;
    } policed_desc_t;

endpackage

`default_nettype wire

// ==== rtl/policer_top.sv ====
// Token-bucket ingress policer top level
`timescale 1ns/1ns
`default_nettype none

module policer_top #(
    parameter int NUM_PORTS = 11
) (
    input  wire                         core_clk_ifc,
    input  wire                         timer_reset,

    // Configuration writes
    input  wire                         cfg_valid,
    input  wire policer_pkg::cfg_write_t cfg,

    input  wire [NUM_PORTS-1:0]         port_enable,

    // Descriptor in and out
    input  wire                         desc_valid,
    input  wire policer_pkg::pkt_desc_t desc_in,
    output logic                        result_valid,
    output policer_pkg::policed_desc_t  result
);

    import policer_pkg::*;

    port_id_t                     lookup_port;
    cir_t                         cir_all [NUM_PORTS];
    cbs_t                         cbs;
    logic [LEVEL_WHOLE_WIDTH-1:0] level_whole;
    logic                         charge_valid;
    byte_len_t                    charge_bytes;

    policer_ctrl #(
        .NUM_PORTS    ( NUM_PORTS    )
    ) i_policer_ctrl (
        .core_clk_ifc ( core_clk_ifc ),
        .timer_reset  ( timer_reset  ),
        .desc_valid   ( desc_valid   ),
        .desc_in      ( desc_in      ),
        .port_enable  ( port_enable  ),
        .cbs          ( cbs          ),
        .level_whole  ( level_whole  ),
        .lookup_port  ( lookup_port  ),
        .charge_valid ( charge_valid ),
        .charge_bytes ( charge_bytes ),
        .result_valid ( result_valid ),
        .result       ( result       )
    );

    policer_cfg_tables #(
        .NUM_PORTS    ( NUM_PORTS    )
    ) i_policer_cfg_tables (
        .core_clk_ifc ( core_clk_ifc ),
        .timer_reset  ( timer_reset  ),
        .cfg_valid    ( cfg_valid    ),
        .cfg          ( cfg          ),
        .lookup_port  ( lookup_port  ),
        .cir_all      ( cir_all      ),
        .cbs          ( cbs          )
    );

    token_bucket_bank #(
        .NUM_PORTS    ( NUM_PORTS    )
    ) i_token_bucket_bank (
        .core_clk_ifc ( core_clk_ifc ),
        .timer_reset  ( timer_reset  ),
        .cir_all      ( cir_all      ),
        .lookup_port  ( lookup_port  ),
        .charge_valid ( charge_valid ),
        .charge_bytes ( charge_bytes ),
        .level_whole  ( level_whole  )
    );

endmodule

`default_nettype wire

// ==== rtl/token_bucket_bank.sv ====
// Per-port fixed-point bucket levels with continuous drain and
// saturating charge
`timescale 1ns/1ns
`default_nettype none

module token_bucket_bank #(
    parameter int NUM_PORTS = 11
) (
    input  wire                                      core_clk_ifc,
    input  wire                                      timer_reset,
    input  wire policer_pkg::cir_t                   cir_all [NUM_PORTS],
    input  wire policer_pkg::port_id_t               lookup_port,
    input  wire                                      charge_valid,
    input  wire policer_pkg::byte_len_t              charge_bytes,
    output logic [policer_pkg::LEVEL_WHOLE_WIDTH-1:0] level_whole
);

    import policer_pkg::*;

    bucket_level_t level [NUM_PORTS];
    bucket_level_t charge_fixed;

    // Whole bytes moved into 24.8 format
    assign charge_fixed = bucket_level_t'(charge_bytes) << FRAC_BITS;

    ////////////////////////////////////////
    // Bucket update per port

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_bucket
        bucket_level_t         drain;
        bucket_level_t         drained;
        logic                  hit;
        logic [BUCKET_WIDTH:0] charged;

        assign drain = bucket_level_t'(cir_all[p]);

        // Floor at zero
        assign drained = (level[p] > drain) ? level[p] - drain : '0;

        assign hit     = charge_valid && (lookup_port == PORT_ID_WIDTH'(p));
        assign charged = {1'b0, drained} + (hit ? {1'b0, charge_fixed} : '0);

        always_ff @(posedge core_clk_ifc) begin
            if (timer_reset) begin
                level[p] <= '0;
            end else if (charged[BUCKET_WIDTH]) begin
                // Carry out means overflow so the level pins to full scale
                level[p] <= '1;
            end else begin
                level[p] <= charged[BUCKET_WIDTH-1:0];
            end
        end
    end

    ////////////////////////////////////////
    // Lookup

    always_comb begin
        if (int'(lookup_port) < NUM_PORTS) begin
            level_whole = level[lookup_port][BUCKET_WIDTH-1:FRAC_BITS];
        end else begin
            level_whole = '0;
        end
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
rtl/policer_pkg.sv
rtl/policer_cfg_tables.sv
rtl/token_bucket_bank.sv
rtl/policer_ctrl.sv
rtl/policer_top.sv
test/policer_tb.sv

// ==== include/policer_tb_tasks.svh ====
// Stimulus helpers, reference bucket model and the directed tests
// for the policer testbench
`ifndef POLICER_TB_TASKS_SVH
`define POLICER_TB_TASKS_SVH

////////////////////////////////////////
// Stimulus helpers

task automatic apply_reset();
    @(negedge core_clk_ifc);
    timer_reset = 1'b1;
    desc_valid  = 1'b0;
    cfg_valid   = 1'b0;
    repeat (RESET_CYCLES) @(negedge core_clk_ifc);
    timer_reset = 1'b0;
endtask

task automatic write_cfg(input table_sel_e sel, input int port, input logic [23:0] data);
    @(negedge core_clk_ifc);
    cfg_valid     = 1'b1;
    cfg.table_sel = sel;
    cfg.port      = port_id_t'(port);
    cfg.data      = data;
    @(negedge core_clk_ifc);
    cfg_valid = 1'b0;
endtask

task automatic load_all_ports(input logic [15:0] cir, input logic [23:0] cbs_val);
    for (int p = 0; p < NUM_PORTS; p++) begin
        write_cfg(TABLE_CIR, p, {8'h00, cir});
        write_cfg(TABLE_CBS, p, cbs_val);
    end
endtask

// Random port in range with a length from 64 to 1500
task automatic random_desc(output pkt_desc_t d);
    logic [31:0] bits;
    draw_bits(4, bits);
    d.ingress_port = port_id_t'(bits % NUM_PORTS);
    draw_bits(4, bits);
    d.egress_port = port_id_t'(bits);
    draw_bits(3, bits);
    d.prio = prio_t'(bits);
    draw_bits(11, bits);
    d.byte_length = byte_len_t'(64 + bits % 1437);
endtask

// Strobe stays high until the next send or finish_burst
task automatic send_desc(input pkt_desc_t d, input logic mark);
    policed_desc_t e;
    @(negedge core_clk_ifc);
    desc_valid  = 1'b1;
    desc_in     = d;
    e.desc      = d;
    e.drop_mark = mark;
    exp_q.push_back(e);
    exp_cycle_q.push_back(cycle_count + 2);
endtask

// The last result is due one falling edge after the strobe drops
task automatic finish_burst();
    @(negedge core_clk_ifc);
    desc_valid = 1'b0;
    for (int i = 0; i < 4 && exp_q.size() != 0; i++) begin
        @(negedge core_clk_ifc);
    end
endtask

task automatic wait_for_cycle(input int target);
    while (cycle_count < target) @(negedge core_clk_ifc);
endtask

////////////////////////////////////////
// Directed tests

task automatic test_mark_all();
    pkt_desc_t d;
    apply_reset();
    port_enable = '1;
    load_all_ports(16'd0, 24'd0);
    for (int n = 0; n < MARK_PACKETS; n++) begin
        random_desc(d);
        send_desc(d, 1'b1);
    end
    finish_burst();
endtask

task automatic test_accept_all();
    pkt_desc_t d;
    apply_reset();
    port_enable = '1;
    load_all_ports(16'hFFFF, 24'hFFFFFF);
    for (int n = 0; n < ACCEPT_PACKETS; n++) begin
        random_desc(d);
        send_desc(d, 1'b0);
    end
    finish_burst();
endtask

// Nothing drains so a plain byte count per port is exact
task automatic test_burst_threshold();
    int          bucket [NUM_PORTS];
    int          cbs_model [NUM_PORTS];
    pkt_desc_t   d;
    logic [31:0] bits;
    logic        mark;
    int          p;
    apply_reset();
    port_enable = '1;
    for (int i = 0; i < NUM_PORTS; i++) begin
        draw_bits(13, bits);
        cbs_model[i] = int'(bits);
        bucket[i]    = 0;
        write_cfg(TABLE_CIR, i, 24'd0);
        write_cfg(TABLE_CBS, i, bits[23:0]);
    end
    for (int n = 0; n < BURST_PACKETS; n++) begin
        random_desc(d);
        p    = int'(d.ingress_port);
        mark = (int'(d.byte_length) + bucket[p]) > cbs_model[p];
        if (!mark) begin
            bucket[p] += int'(d.byte_length);
        end
        send_desc(d, mark);
    end
    finish_burst();
endtask

// Bucket loses cir/256 bytes each cycle after the first charge
task automatic test_drain_rate();
    pkt_desc_t   d;
    logic [31:0] bits;
    int          cir;
    int          first_sample;
    int          marked_steps;
    int          clear_steps;
    apply_reset();
    port_enable = '1;
    for (int r = 0; r < DRAIN_ROUNDS; r++) begin
        draw_bits(12, bits);
        cir = 256 + int'(bits);
        write_cfg(TABLE_CIR, r, 24'(cir));
        write_cfg(TABLE_CBS, r, 24'd1000);
        random_desc(d);
        d.ingress_port = port_id_t'(r);
        d.byte_length  = 16'd1000;

        send_desc(d, 1'b0);
        first_sample = cycle_count + 1;
        finish_burst();

        // Under 992 bytes gone leaves at least 8 whole bytes
        marked_steps = (992 * 256) / cir;
        clear_steps  = (1000 * 256 + cir - 1) / cir + 4;

        wait_for_cycle(first_sample + marked_steps - 1);
        send_desc(d, 1'b1);
        finish_burst();

        wait_for_cycle(first_sample + clear_steps - 1);
        send_desc(d, 1'b0);
        finish_burst();
    end
endtask

task automatic test_disable();
    pkt_desc_t   d;
    logic [31:0] bits;
    apply_reset();
    load_all_ports(16'd0, 24'd0);
    draw_bits(NUM_PORTS, bits);
    port_enable = bits[NUM_PORTS-1:0];
    for (int n = 0; n < DISABLE_PACKETS; n++) begin
        random_desc(d);
        send_desc(d, port_enable[d.ingress_port]);
    end
    finish_burst();

    // Port 12 lies past the tables so neither write may land anywhere
    write_cfg(TABLE_CBS, 12, 24'hFFFFFF);
    write_cfg(TABLE_CIR, 12, 24'h00FFFF);
    for (int p = 0; p < NUM_PORTS; p++) begin
        random_desc(d);
        d.ingress_port = port_id_t'(p);
        send_desc(d, port_enable[p]);
    end
    finish_burst();
endtask

`endif

// ==== test/policer_tb.sv ====
// Policer testbench top with clock, reset, DUT, LFSR, result monitor,
// watchdog and test sequence
`timescale 1ns/1ns
`default_nettype none

module policer_tb;

    import policer_pkg::*;

    localparam int NUM_PORTS       = 11;
    localparam int CLK_PERIOD      = 10;
    localparam int RESET_CYCLES    = 8;

    localparam int MARK_PACKETS    = 200;
    localparam int ACCEPT_PACKETS  = 200;
    localparam int BURST_PACKETS   = 200;
    localparam int DRAIN_ROUNDS    = 4;
    localparam int DISABLE_PACKETS = 100;

    localparam int TOTAL_PACKETS = MARK_PACKETS + ACCEPT_PACKETS + BURST_PACKETS +
                                   3 * DRAIN_ROUNDS + DISABLE_PACKETS + NUM_PORTS;
    // Slowest drain is one byte per cycle over a 1000 byte fill
    localparam int DRAIN_WAIT_CYCLES = DRAIN_ROUNDS * 1100;
    localparam int SETUP_CYCLES      = 5 * (RESET_CYCLES + 2) + 5 * 4 * NUM_PORTS + 16;
    localparam int MARGIN_CYCLES     = 500;
    localparam int WATCHDOG_CYCLES   = TOTAL_PACKETS * 4 + DRAIN_WAIT_CYCLES +
                                       SETUP_CYCLES + MARGIN_CYCLES;

    logic                 core_clk_ifc;
    logic                 timer_reset;
    logic                 cfg_valid;
    cfg_write_t           cfg;
    logic [NUM_PORTS-1:0] port_enable;
    logic                 desc_valid;
    pkt_desc_t            desc_in;
    logic                 result_valid;
    policed_desc_t        result;

    int                   cycle_count = 0;
    logic [15:0]          lfsr_state  = 16'd2;
    policed_desc_t        exp_q [$];
    int                   exp_cycle_q [$];

    policer_top #(
        .NUM_PORTS    ( NUM_PORTS    )
    ) i_policer_top (
        .core_clk_ifc ( core_clk_ifc ),
        .timer_reset  ( timer_reset  ),
        .cfg_valid    ( cfg_valid    ),
        .cfg          ( cfg          ),
        .port_enable  ( port_enable  ),
        .desc_valid   ( desc_valid   ),
        .desc_in      ( desc_in      ),
        .result_valid ( result_valid ),
        .result       ( result       )
    );

    ////////////////////////////////////////
    // Clock and cycle counter

    initial begin
        core_clk_ifc = 1'b0;
        forever #(CLK_PERIOD / 2) core_clk_ifc = ~core_clk_ifc;
    end

    always @(posedge core_clk_ifc) begin
        cycle_count <= cycle_count + 1;
    end

    ////////////////////////////////////////
    // Error handling and checks

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic compare_policed(input string name, input policed_desc_t got,
                                   input policed_desc_t exp);
        if (got !== exp) begin
            fail_run($sformatf("FAILED at %0t ns: %s got %h expected %h",
                               $time, name, got, exp));
        end
    endtask

    task automatic compare_cycle(input string name, input int got, input int exp);
        if (got != exp) begin
            fail_run($sformatf("FAILED at %0t ns: %s cycle got %0d expected %0d",
                               $time, name, got, exp));
        end
    endtask

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    `include "policer_tb_tasks.svh"

    ////////////////////////////////////////
    // Result monitor

    // Outputs change on the rising edge so sample on the falling one
    always @(negedge core_clk_ifc) begin
        if (!timer_reset && result_valid) begin
            if (exp_q.size() == 0) begin
                fail_run("A result came out while no packet was pending");
            end else begin
                compare_policed("result", result, exp_q.pop_front());
                compare_cycle("result_valid", cycle_count, exp_cycle_q.pop_front());
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run("Timeout: the tests did not finish within the expected time");
    end

    ////////////////////////////////////////
    // Test sequence

    initial begin
        timer_reset = 1'b1;
        cfg_valid   = 1'b0;
        cfg         = '0;
        port_enable = '0;
        desc_valid  = 1'b0;
        desc_in     = '0;

        test_mark_all();
        test_accept_all();
        test_burst_threshold();
        test_drain_rate();
        test_disable();

        if (exp_q.size() != 0) begin
            fail_run("Expected results were still pending at the end of the tests");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

`default_nettype wire
